/* rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // funct3 codes of the integer ALU group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_COPY2 = 4'd10,
        ALU_MUL   = 4'd11
    } alu_op_t;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_RS2 = 2'd0,
        OP2_IMI = 2'd1,
        OP2_IMU = 2'd2
    } op2_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, three ways of reading it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

    typedef struct packed {
        alu_op_t   alu_op;
        op1_sel_t  op1_sel;
        op2_sel_t  op2_sel;
        logic      rf_wen;
        reg_addr_t wb_addr;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_u inst;
        ctrl_t ctrl;
        word_t imm_i;
        word_t imm_u;
    } id_ds_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        word_t op1_data;
        word_t op2_data;
    } ds_exe_t;

    typedef struct packed {
        logic      valid;
        logic      rf_wen;
        reg_addr_t wb_addr;
        logic      is_mul;
        word_t     result;
        word_t     pp_ll;
        word_t     pp_lh;
        word_t     pp_hl;
    } exe_mem_t;

    typedef struct packed {
        logic      valid;
        logic      can_forward;
        reg_addr_t addr;
        word_t     wdata;
    } fw_ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     wdata;
    } wb_fw_t;

endpackage

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   inst_valid,
    input  addr_t  pc,
    input  inst_u  inst,
    input  logic   stall,
    output id_ds_t id_ds
);

    logic  dec_valid;
    addr_t dec_pc;
    inst_u dec_inst;
    ctrl_t ctrl;
    logic  known;

    // shared funct3 decode where alt picks SUB or SRA
    function automatic alu_op_t alu_from_f3(logic [2:0] funct3, logic alt);
        case (funct3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && inst_valid) begin
            dec_pc   <= pc;
            dec_inst <= inst;
        end
    end

    always_comb begin
        ctrl.alu_op  = ALU_ADD;
        ctrl.op1_sel = OP1_RS1;
        ctrl.op2_sel = OP2_RS2;
        ctrl.wb_addr = dec_inst.r_fmt.rd;
        known        = 1'b1;
        case (dec_inst.r_fmt.opcode)
            OPC_OP: begin
                if (dec_inst.r_fmt.funct7 == FUNCT7_MULDIV) begin
                    ctrl.alu_op = ALU_MUL;
                    known       = dec_inst.r_fmt.funct3 == F3_ADD;
                end else begin
                    ctrl.alu_op = alu_from_f3(dec_inst.r_fmt.funct3,
                                              dec_inst.r_fmt.funct7 == FUNCT7_ALT);
                    known = dec_inst.r_fmt.funct7 == 7'd0 ||
                            (dec_inst.r_fmt.funct7 == FUNCT7_ALT &&
                             (dec_inst.r_fmt.funct3 == F3_ADD ||
                              dec_inst.r_fmt.funct3 == F3_SR));
                end
            end
            OPC_OP_IMM: begin
                // imm[10] is instr bit 30 and only matters for shifts
                ctrl.alu_op  = alu_from_f3(dec_inst.i_fmt.funct3,
                                           dec_inst.i_fmt.funct3 == F3_SR &&
                                           dec_inst.i_fmt.imm[10]);
                ctrl.op2_sel = OP2_IMI;
            end
            OPC_LUI: begin
                ctrl.alu_op  = ALU_COPY2;
                ctrl.op1_sel = OP1_ZERO;
                ctrl.op2_sel = OP2_IMU;
            end
            OPC_AUIPC: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMU;
            end
            default: known = 1'b0;
        endcase
        ctrl.rf_wen = known && ctrl.wb_addr != '0;
    end

    assign id_ds = '{
        valid: dec_valid,
        pc:    dec_pc,
        inst:  dec_inst,
        ctrl:  ctrl,
        imm_i: {{20{dec_inst.i_fmt.imm[11]}}, dec_inst.i_fmt.imm},
        imm_u: {dec_inst.u_fmt.imm, 12'd0}
    };

    // an accepted word always yields a defined control word
    a_ctrl_known: assert property (@(posedge clk) disable iff (!arst_n)
        id_ds.valid |-> !$isunknown(id_ds.ctrl));

endmodule

/* data_select_stage.sv */
`timescale 1ns/1ps

module data_select_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  id_ds_t   id_ds,
    input  word_t    regfile [32],
    input  fw_ctrl_t exe_fw,
    input  fw_ctrl_t mem_fw,
    input  wb_fw_t   wb_fw,
    output logic     stall,
    output ds_exe_t  ds_exe
);

    id_ds_t    ds_q;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      use_rs1;
    logic      use_rs2;
    logic      exe_rs1;
    logic      exe_rs2;
    logic      mem_rs1;
    logic      mem_rs2;
    logic      wb_rs1;
    logic      wb_rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op1_data;
    word_t     op2_data;

    function automatic logic src_hit(logic used, logic valid, reg_addr_t addr,
                                     reg_addr_t src);
        return used && valid && addr == src && src != '0;
    endfunction

    // youngest producer wins
    function automatic word_t pick(reg_addr_t src, logic e_hit, logic m_hit, logic w_hit,
                                   word_t e_data, word_t m_data, word_t w_data,
                                   word_t rf_data);
        if (src == '0) return '0;
        if (e_hit)     return e_data;
        if (m_hit)     return m_data;
        if (w_hit)     return w_data;
        return rf_data;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_q <= '0;
        end else if (!stall) begin
            ds_q <= id_ds;
        end
    end

    assign rs1_addr = ds_q.inst.r_fmt.rs1;
    assign rs2_addr = ds_q.inst.r_fmt.rs2;

    // immediate bits in the rs fields must not cause false hazards
    assign use_rs1 = ds_q.ctrl.op1_sel == OP1_RS1;
    assign use_rs2 = ds_q.ctrl.op2_sel == OP2_RS2;

    assign exe_rs1 = src_hit(use_rs1, exe_fw.valid, exe_fw.addr, rs1_addr);
    assign exe_rs2 = src_hit(use_rs2, exe_fw.valid, exe_fw.addr, rs2_addr);
    assign mem_rs1 = src_hit(use_rs1, mem_fw.valid, mem_fw.addr, rs1_addr);
    assign mem_rs2 = src_hit(use_rs2, mem_fw.valid, mem_fw.addr, rs2_addr);
    assign wb_rs1  = src_hit(use_rs1, wb_fw.valid, wb_fw.addr, rs1_addr);
    assign wb_rs2  = src_hit(use_rs2, wb_fw.valid, wb_fw.addr, rs2_addr);

    // wb always forwards so only exe and mem can hold us
    assign stall = ds_q.valid &&
                   ((!exe_fw.can_forward && (exe_rs1 || exe_rs2)) ||
                    (!mem_fw.can_forward && (mem_rs1 || mem_rs2)));

    assign rs1_data = pick(rs1_addr, exe_rs1, mem_rs1, wb_rs1,
                           exe_fw.wdata, mem_fw.wdata, wb_fw.wdata, regfile[rs1_addr]);
    assign rs2_data = pick(rs2_addr, exe_rs2, mem_rs2, wb_rs2,
                           exe_fw.wdata, mem_fw.wdata, wb_fw.wdata, regfile[rs2_addr]);

    always_comb begin
        case (ds_q.ctrl.op1_sel)
            OP1_RS1: op1_data = rs1_data;
            OP1_PC:  op1_data = ds_q.pc;
            default: op1_data = '0;
        endcase
        case (ds_q.ctrl.op2_sel)
            OP2_RS2: op2_data = rs2_data;
            OP2_IMI: op2_data = ds_q.imm_i;
            OP2_IMU: op2_data = ds_q.imm_u;
            default: op2_data = '0;
        endcase
    end

    assign ds_exe = '{
        valid:    ds_q.valid && !stall,
        pc:       ds_q.pc,
        ctrl:     ds_q.ctrl,
        op1_data: op1_data,
        op2_data: op2_data
    };

    // exe and mem always move on so a stall clears within two cycles
    a_stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> ##[1:2] !stall);

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  ds_exe_t  ds_exe,
    output fw_ctrl_t exe_fw,
    output exe_mem_t exe_mem
);

    ds_exe_t exe_q;
    word_t   a;
    word_t   b;
    word_t   result;
    word_t   pp_ll;
    word_t   pp_lh;
    word_t   pp_hl;
    logic    is_mul;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_q <= '0;
        end else begin
            exe_q <= ds_exe;
        end
    end

    assign a = exe_q.op1_data;
    assign b = exe_q.op2_data;

    always_comb begin
        case (exe_q.ctrl.alu_op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << b[4:0];
            ALU_SLT:   result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'd0, a < b};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> b[4:0];
            ALU_SRA:   result = $signed(a) >>> b[4:0];
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_COPY2: result = b;
            default:   result = '0;
        endcase
    end

    assign is_mul = exe_q.ctrl.alu_op == ALU_MUL;

    // hi x hi only reaches bits above 31
    assign pp_ll = 32'(a[15:0]) * 32'(b[15:0]);
    assign pp_lh = 32'(a[15:0]) * 32'(b[31:16]);
    assign pp_hl = 32'(a[31:16]) * 32'(b[15:0]);

    assign exe_fw = '{
        valid:       exe_q.valid && exe_q.ctrl.rf_wen,
        can_forward: exe_q.ctrl.alu_op == ALU_COPY2,
        addr:        exe_q.ctrl.wb_addr,
        wdata:       result
    };

    assign exe_mem = '{
        valid:   exe_q.valid,
        rf_wen:  exe_q.ctrl.rf_wen,
        wb_addr: exe_q.ctrl.wb_addr,
        is_mul:  is_mul,
        result:  result,
        pp_ll:   pp_ll,
        pp_lh:   pp_lh,
        pp_hl:   pp_hl
    };

    a_alu_op_known: assert property (@(posedge clk) disable iff (!arst_n)
        exe_q.valid |-> exe_q.ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
                                                  ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
                                                  ALU_OR, ALU_AND, ALU_COPY2, ALU_MUL});

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  exe_mem_t  exe_mem,
    output fw_ctrl_t  mem_fw,
    output wb_fw_t    wb_fw,
    output word_t     regfile [32],
    output logic      retire_valid,
    output reg_addr_t retire_addr,
    output word_t     retire_data
);

    exe_mem_t  mem_q;
    word_t     mem_data;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_q <= '0;
        end else begin
            mem_q <= exe_mem;
        end
    end

    // product is only complete on the way into wb
    assign mem_data = mem_q.is_mul ?
                      mem_q.pp_ll + ((mem_q.pp_lh + mem_q.pp_hl) << 16) :
                      mem_q.result;

    assign mem_fw = '{
        valid:       mem_q.valid && mem_q.rf_wen,
        can_forward: !mem_q.is_mul,
        addr:        mem_q.wb_addr,
        wdata:       mem_q.result
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_q.valid && mem_q.rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= mem_q.wb_addr;
        wb_data <= mem_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regfile[i] <= '0;
            end
        end else if (wb_valid) begin
            regfile[wb_addr] <= wb_data;
        end
    end

    assign wb_fw = '{
        valid: wb_valid,
        addr:  wb_addr,
        wdata: wb_data
    };

    assign retire_valid = wb_valid;
    assign retire_addr  = wb_addr;
    assign retire_data  = wb_data;

    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> wb_addr != '0);

endmodule

/* int_core_top.sv */
`timescale 1ns/1ps

module int_core_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      inst_valid,
    input  addr_t     pc,
    input  inst_u     inst,
    output logic      stall,
    output logic      retire_valid,
    output reg_addr_t retire_addr,
    output word_t     retire_data
);

    id_ds_t   id_ds;
    ds_exe_t  ds_exe;
    exe_mem_t exe_mem;
    fw_ctrl_t exe_fw;
    fw_ctrl_t mem_fw;
    wb_fw_t   wb_fw;
    word_t    regfile [32];

    decode_stage u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .pc         (pc),
        .inst       (inst),
        .stall      (stall),
        .id_ds      (id_ds)
    );

    data_select_stage u_data_select (
        .clk     (clk),
        .arst_n  (arst_n),
        .id_ds   (id_ds),
        .regfile (regfile),
        .exe_fw  (exe_fw),
        .mem_fw  (mem_fw),
        .wb_fw   (wb_fw),
        .stall   (stall),
        .ds_exe  (ds_exe)
    );

    execute_stage u_execute (
        .clk     (clk),
        .arst_n  (arst_n),
        .ds_exe  (ds_exe),
        .exe_fw  (exe_fw),
        .exe_mem (exe_mem)
    );

    result_stage u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .exe_mem      (exe_mem),
        .mem_fw       (mem_fw),
        .wb_fw        (wb_fw),
        .regfile      (regfile),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data)
    );

endmodule

/* tb_ref_model.svh */
// columns of one expected write: write enable, register, data
typedef struct packed {
    logic        wen;
    logic [4:0]  addr;
    logic [31:0] data;
} ref_wr_t;

// architectural register state
logic [31:0] model_rf [32];

function automatic void reset_model();
    foreach (model_rf[i]) begin
        model_rf[i] = '0;
    end
endfunction

// executes one instruction on the model registers
function automatic ref_wr_t step_model(logic [31:0] ins, logic [31:0] ins_pc);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        is_op;
    logic        alt;
    logic        known;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    ref_wr_t     wr;
    opc   = ins[6:0];
    rd    = ins[11:7];
    f3    = ins[14:12];
    is_op = opc == 7'b0110011;
    a     = model_rf[ins[19:15]];
    // register form takes rs2, immediate form the sign extended imm
    b     = is_op ? model_rf[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    alt   = ins[30] && (is_op || f3 == 3'd5);
    known = 1'b1;
    res   = '0;
    if (is_op && ins[31:25] == 7'b0000001) begin
        res = a * b;
    end else if (is_op || opc == 7'b0010011) begin
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'd0, $signed(a) < $signed(b)};
            3'd3: res = {31'd0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
    end else if (opc == 7'b0110111) begin
        res = {ins[31:12], 12'd0};
    end else if (opc == 7'b0010111) begin
        res = ins_pc + {ins[31:12], 12'd0};
    end else begin
        known = 1'b0;
    end
    wr.wen  = known && rd != 5'd0;
    wr.addr = rd;
    wr.data = res;
    if (wr.wen) begin
        model_rf[rd] = res;
    end
    return wr;
endfunction

/* tb_int_core.sv */
`timescale 1ns/1ps

module tb_int_core import rv_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int PIPE_DEPTH   = 5;
    localparam int N_INDEP      = 40;
    localparam int N_CHAIN      = 10;
    localparam int N_STALL      = 6;
    localparam int N_MUL        = 8;
    localparam int N_MIXED      = 80;
    localparam int TOTAL_INSTS  = 17 + N_INDEP + 8 * N_CHAIN + 6 * N_STALL + 6 * N_MUL + 7 + N_MIXED;
    localparam logic [6:0] U_LUI   = 7'b0110111;
    localparam logic [6:0] U_AUIPC = 7'b0010111;

    logic      clk;
    logic      arst_n;
    logic      inst_valid;
    addr_t     pc;
    inst_u     inst;
    logic      stall;
    logic      retire_valid;
    reg_addr_t retire_addr;
    word_t     retire_data;
    addr_t     next_pc = 32'h0000_1000;
    int        stall_cycles = 0;

    `include "tb_ref_model.svh"

    ref_wr_t exp_q [$];

    int_core_top uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .pc           (pc),
        .inst         (inst),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %08h expected %08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] utype_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [4:0] low_reg();
        return 5'($urandom_range(8, 1));
    endfunction

    // any of the R and I type ALU ops
    function automatic logic [31:0] random_alu(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        logic [11:0] imm;
        logic [4:0]  sh;
        imm = 12'($urandom);
        sh  = 5'($urandom);
        case ($urandom_range(18, 0))
            0:  return rtype_word(7'h00, rs2, rs1, 3'd0, rd);
            1:  return rtype_word(7'h20, rs2, rs1, 3'd0, rd);
            2:  return rtype_word(7'h00, rs2, rs1, 3'd1, rd);
            3:  return rtype_word(7'h00, rs2, rs1, 3'd2, rd);
            4:  return rtype_word(7'h00, rs2, rs1, 3'd3, rd);
            5:  return rtype_word(7'h00, rs2, rs1, 3'd4, rd);
            6:  return rtype_word(7'h00, rs2, rs1, 3'd5, rd);
            7:  return rtype_word(7'h20, rs2, rs1, 3'd5, rd);
            8:  return rtype_word(7'h00, rs2, rs1, 3'd6, rd);
            9:  return rtype_word(7'h00, rs2, rs1, 3'd7, rd);
            10: return itype_word(imm, rs1, 3'd0, rd);
            11: return itype_word(imm, rs1, 3'd2, rd);
            12: return itype_word(imm, rs1, 3'd3, rd);
            13: return itype_word(imm, rs1, 3'd4, rd);
            14: return itype_word(imm, rs1, 3'd6, rd);
            15: return itype_word(imm, rs1, 3'd7, rd);
            16: return itype_word({7'h00, sh}, rs1, 3'd1, rd);
            17: return itype_word({7'h00, sh}, rs1, 3'd5, rd);
            default: return itype_word({7'h20, sh}, rs1, 3'd5, rd);
        endcase
    endfunction

    function automatic logic [31:0] random_any();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        case ($urandom_range(9, 0))
            0: return rtype_word(7'h01, rs2, rs1, 3'd0, rd);
            1: return utype_word(20'($urandom), rd, U_LUI);
            2: return utype_word(20'($urandom), rd, U_AUIPC);
            default: return random_alu(rd, rs1, rs2);
        endcase
    endfunction

    // held until a falling edge shows stall low, taken at the next rising edge
    task automatic issue_inst(logic [31:0] word);
        ref_wr_t wr;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        pc         = next_pc;
        while (stall) begin
            @(negedge clk);
        end
        wr = step_model(word, next_pc);
        if (wr.wen) begin
            exp_q.push_back(wr);
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic load_reg(logic [4:0] rd);
        issue_inst(utype_word(20'($urandom), rd, U_LUI));
        issue_inst(itype_word(12'($urandom), rd, 3'd0, rd));
    endtask

    // x0 targets retire nothing, so idle past them
    task automatic drain_pipe();
        @(negedge clk);
        inst_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (PIPE_DEPTH) @(negedge clk);
    endtask

    task automatic finish_group(int base, int n);
        drain_pipe();
        check_value("stall_cycles", 32'(stall_cycles - base), 32'(n));
    endtask

    always @(negedge clk) begin
        if (arst_n && stall) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    initial begin : compare
        ref_wr_t exp;
        forever begin
            @(negedge clk);
            if (arst_n && retire_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("retire pulse seen with no register write expected");
                end else begin
                    exp = exp_q.pop_front();
                    check_value("retire_addr", 32'(retire_addr), 32'(exp.addr));
                    check_value("retire_data", retire_data, exp.data);
                end
            end
        end
    end

    initial begin : watchdog
        #((TOTAL_INSTS * 12 + RESET_CYCLES) * CLK_PERIOD);
        abort_run("timeout: retires stopped before the program finished");
    end

    initial begin : stimulus
        int base;
        void'($urandom(32'h6df2_532e));
        reset_model();
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        pc         = '0;
        inst       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        check_value("stall", 32'(stall), 32'd0);

        // sources x1..x8, independent ops write x16..x31
        for (int r = 1; r <= 8; r++) begin
            load_reg(5'(r));
        end
        drain_pipe();
        base = stall_cycles;
        issue_inst(rtype_word(7'h00, 5'd0, 5'd0, 3'd6, 5'd16));
        for (int i = 0; i < N_INDEP; i++) begin
            issue_inst(random_alu(5'($urandom_range(31, 16)), low_reg(), low_reg()));
        end
        finish_group(base, 0);

        // mem and wb forwarding chains
        base = stall_cycles;
        for (int i = 0; i < N_CHAIN; i++) begin
            issue_inst(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd10));
            issue_inst(itype_word(12'($urandom), 5'd3, 3'd4, 5'd20));
            issue_inst(rtype_word(7'h20, 5'd4, 5'd10, 3'd5, 5'd11));
            issue_inst(itype_word(12'($urandom), 5'd10, 3'd4, 5'd12));
            issue_inst(itype_word(12'($urandom), 5'd1, 3'd0, 5'd1));
            issue_inst(rtype_word(7'h20, 5'd7, 5'd12, 3'd5, 5'd13));
            issue_inst(rtype_word(7'h00, 5'd8, 5'd6, 3'd0, 5'd22));
            issue_inst(rtype_word(7'h00, 5'd12, 5'd13, 3'd0, 5'd14));
        end
        finish_group(base, 0);

        // exe stall on rs1, on rs2, and none behind LUI
        for (int i = 0; i < N_STALL; i++) begin
            base = stall_cycles;
            issue_inst(random_alu(5'd10, low_reg(), low_reg()));
            issue_inst(random_alu(5'd11, 5'd10, low_reg()));
            finish_group(base, 1);
            base = stall_cycles;
            issue_inst(random_alu(5'd12, low_reg(), low_reg()));
            issue_inst(rtype_word(7'h00, 5'd12, 5'd3, 3'd0, 5'd13));
            finish_group(base, 1);
            base = stall_cycles;
            issue_inst(utype_word(20'($urandom), 5'd14, U_LUI));
            issue_inst(random_alu(5'd15, 5'd14, low_reg()));
            finish_group(base, 0);
        end

        // dependent MUL stalls on exe, then on mem
        for (int i = 0; i < N_MUL; i++) begin
            load_reg(5'd1);
            load_reg(5'd2);
            drain_pipe();
            base = stall_cycles;
            issue_inst(rtype_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd10));
            issue_inst(rtype_word(7'h00, 5'd3, 5'd10, 3'd0, 5'd11));
            finish_group(base, 2);
        end

        // x0 writes dropped, AUIPC, then a mixed program
        issue_inst(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        issue_inst(itype_word(12'h5a5, 5'd3, 3'd0, 5'd0));
        issue_inst(rtype_word(7'h00, 5'd0, 5'd0, 3'd6, 5'd15));
        issue_inst(itype_word(12'h123, 5'd0, 3'd0, 5'd16));
        issue_inst(utype_word(20'($urandom), 5'd17, U_AUIPC));
        issue_inst(utype_word(20'h00000, 5'd18, U_AUIPC));
        issue_inst(utype_word(20'($urandom), 5'd19, U_AUIPC));
        drain_pipe();
        for (int i = 0; i < N_MIXED; i++) begin
            issue_inst(random_any());
        end
        drain_pipe();

        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected writes never retired", exp_q.size()));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+.
rv_pkg.sv
decode_stage.sv
data_select_stage.sv
execute_stage.sv
result_stage.sv
int_core_top.sv
tb_int_core.sv
